// File: Makefile
# Verilator flow for the PS/2 keyboard receiver

VERILATOR ?= verilator
TOP       ?= tb_ps2_keyboard
VLOG_F    ?= vlog.f
VFLAGS    ?= --timing --assert

OBJ_DIR := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(VLOG_F)

# the simulation binary exits non-zero on $fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(VLOG_F)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/key_event_queue.sv
`timescale 1ns/1ps
`default_nettype none

module key_event_queue import ps2_kbd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       wr_valid,
  input  wire logic [7:0] wr_scan,
  input  wire logic [7:0] wr_ascii,
  input  wire logic       wr_extended,
  input  wire logic       wr_released,
  input  wire logic       evt_credit,
  output logic            evt_valid,
  output logic [7:0]      evt_scan,
  output logic [7:0]      evt_ascii,
  output logic            evt_extended,
  output logic            evt_released,
  output logic            evt_overflow
);

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------

  logic [7:0] mem_scan [EVQ_DEPTH];
  logic [7:0] mem_ascii [EVQ_DEPTH];
  logic       mem_ext [EVQ_DEPTH];
  logic       mem_rel [EVQ_DEPTH];

  logic [EVQ_PTR_W-1:0] wr_ptr;
  logic [EVQ_PTR_W-1:0] rd_ptr;
  logic [EVQ_PTR_W:0]   count;
  logic [CREDIT_W-1:0]  credit_cnt;
  // credits left once the event now on the bus is paid for
  logic [CREDIT_W-1:0]  credit_avail;
  logic                 empty;
  logic                 full;
  logic                 push;
  logic                 pop;

  assign empty = (count == '0);
  // msb alone marks full for a power of two depth
  assign full = count[EVQ_PTR_W];
  assign credit_avail = credit_cnt - CREDIT_W'(evt_valid);
  assign push = wr_valid && !full;
  assign pop = !empty && (credit_avail != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem_scan[wr_ptr] <= wr_scan;
      mem_ascii[wr_ptr] <= wr_ascii;
      mem_ext[wr_ptr] <= wr_extended;
      mem_rel[wr_ptr] <= wr_released;
    end
    if (pop) begin
      evt_scan <= mem_scan[rd_ptr];
      evt_ascii <= mem_ascii[rd_ptr];
      evt_extended <= mem_ext[rd_ptr];
      evt_released <= mem_rel[rd_ptr];
    end
  end

  // ------------------------------------------------------------
  // pointers, credits, overflow
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_cnt <= CREDIT_W'(CONSUMER_CREDITS);
      evt_valid <= 1'b0;
      evt_overflow <= 1'b0;
    end else begin
      evt_valid <= pop;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // spend on send, refill on return, both cancel
      case ({evt_valid, evt_credit})
        2'b10: credit_cnt <= credit_cnt - 1'b1;
        2'b01: credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      // sticky until reset
      if (wr_valid && full) begin
        evt_overflow <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // consumer returned more credits than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= CREDIT_W'(CONSUMER_CREDITS));

  // a send always has a credit behind it
  a_send_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    evt_valid |-> credit_cnt != '0);

endmodule

`default_nettype wire

// File: logic/ps2_ascii_map.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_ascii_map import ps2_kbd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       key_valid,
  input  wire logic [7:0] key_scan,
  input  wire logic       key_extended,
  input  wire logic       key_released,
  input  wire logic       shift_on,
  input  wire logic       caps_on,
  output logic            map_valid,
  output logic [7:0]      map_scan,
  output logic [7:0]      map_ascii,
  output logic            map_extended,
  output logic            map_released
);

  // ------------------------------------------------------------
  // set 2 lookup tables
  // ------------------------------------------------------------

  // lower case letter, none if not a letter
  function automatic logic [7:0] letter_lower(input logic [7:0] sc);
    case (sc)
      8'h1C: return "a";  8'h32: return "b";  8'h21: return "c";
      8'h23: return "d";  8'h24: return "e";  8'h2B: return "f";
      8'h34: return "g";  8'h33: return "h";  8'h43: return "i";
      8'h3B: return "j";  8'h42: return "k";  8'h4B: return "l";
      8'h3A: return "m";  8'h31: return "n";  8'h44: return "o";
      8'h4D: return "p";  8'h15: return "q";  8'h2D: return "r";
      8'h1B: return "s";  8'h2C: return "t";  8'h3C: return "u";
      8'h2A: return "v";  8'h1D: return "w";  8'h22: return "x";
      8'h35: return "y";  8'h1A: return "z";
      default: return ASCII_NONE;
    endcase
  endfunction

  // digit row, shifted symbol in the upper byte
  function automatic logic [15:0] digit_pair(input logic [7:0] sc);
    case (sc)
      8'h16: return {"!", "1"};
      8'h1E: return {"@", "2"};
      8'h26: return {"#", "3"};
      8'h25: return {"$", "4"};
      8'h2E: return {"%", "5"};
      8'h36: return {"^", "6"};
      8'h3D: return {"&", "7"};
      8'h3E: return {"*", "8"};
      8'h46: return {"(", "9"};
      8'h45: return {")", "0"};
      default: return {ASCII_NONE, ASCII_NONE};
    endcase
  endfunction

  // ------------------------------------------------------------
  // translation
  // ------------------------------------------------------------

  logic [7:0]  lower;
  logic [15:0] digits;
  logic [7:0]  ascii_next;

  assign lower = letter_lower(key_scan);
  assign digits = digit_pair(key_scan);

  always_comb begin
    ascii_next = ASCII_NONE;
    if (key_extended) begin
      // keypad and navigation keys stay unmapped
      ascii_next = ASCII_NONE;
    end else if (lower != ASCII_NONE) begin
      // upper case is lower minus 0x20
      ascii_next = (shift_on ^ caps_on) ? (lower - 8'h20) : lower;
    end else if (digits[7:0] != ASCII_NONE) begin
      ascii_next = shift_on ? digits[15:8] : digits[7:0];
    end else begin
      case (key_scan)
        8'h29: ascii_next = " ";
        8'h5A: ascii_next = 8'h0D;
        8'h66: ascii_next = 8'h08;
        default: ascii_next = ASCII_NONE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (key_valid) begin
      map_scan <= key_scan;
      map_ascii <= ascii_next;
      map_extended <= key_extended;
      map_released <= key_released;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      map_valid <= 1'b0;
    end else begin
      map_valid <= key_valid;
    end
  end

endmodule

`default_nettype wire

// File: logic/ps2_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx import ps2_kbd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       ps2_clk,
  input  wire logic       ps2_data,
  output logic            rx_valid,
  output logic [7:0]      rx_byte,
  output logic            frame_error
);

  // ------------------------------------------------------------
  // synchronizers and edge detect
  // ------------------------------------------------------------

  logic [SYNC_STAGES-1:0] clk_sync;
  logic [SYNC_STAGES-1:0] data_sync;
  // previous synced clock for the falling edge
  logic                   clk_last;
  logic                   clk_fall;
  logic                   data_bit;

  // idle level of both lines is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_sync <= '1;
      data_sync <= '1;
      clk_last <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
      data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
      clk_last <= clk_sync[SYNC_STAGES-1];
    end
  end

  assign clk_fall = clk_last & ~clk_sync[SYNC_STAGES-1];
  assign data_bit = data_sync[SYNC_STAGES-1];

  // ------------------------------------------------------------
  // frame assembly
  // ------------------------------------------------------------

  logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
  logic [IDLE_CNT_W-1:0]         idle_cnt;
  // first ten bits, lsb first so bit 0 is the start bit
  logic [FRAME_BITS-2:0]         shift_q;
  logic [FRAME_BITS-1:0]         frame;
  logic                          last_bit;
  logic                          frame_ok;

  assign last_bit = (bit_cnt == ($clog2(FRAME_BITS))'(FRAME_BITS - 1));
  // stop bit arrives on the last edge and is used straight from the synchronizer
  assign frame = {data_bit, shift_q};
  // start low, stop high, odd parity over data plus parity
  assign frame_ok = !frame[0] && frame[FRAME_BITS-1] && (^frame[FRAME_BITS-2:1]);

  always_ff @(posedge clk) begin
    if (clk_fall) begin
      shift_q <= {data_bit, shift_q[FRAME_BITS-2:1]};
    end
    if (clk_fall && last_bit && frame_ok) begin
      rx_byte <= frame[8:1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
      idle_cnt <= '0;
      rx_valid <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      frame_error <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        if (last_bit) begin
          bit_cnt <= '0;
          rx_valid <= frame_ok;
          frame_error <= !frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (bit_cnt != '0) begin
        // partial frame went quiet, start over at the next edge
        if (idle_cnt == IDLE_CNT_W'(IDLE_TIMEOUT_CYCLES - 1)) begin
          bit_cnt <= '0;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // a frame outcome never lasts more than one cycle
  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (rx_valid || frame_error) |=> !(rx_valid || frame_error));

endmodule

`default_nettype wire

// File: logic/ps2_kbd_pkg.sv
`default_nettype none

package ps2_kbd_pkg;

  // ------------------------------------------------------------
  // ps/2 line protocol
  // ------------------------------------------------------------

  // start + 8 data + parity + stop
  localparam int FRAME_BITS = 11;

  // flops per synchronizer chain
  localparam int SYNC_STAGES = 2;

  // clk cycles with no ps/2 edge before a partial frame is dropped
  localparam int IDLE_TIMEOUT_CYCLES = 2000;
  localparam int IDLE_CNT_W = $clog2(IDLE_TIMEOUT_CYCLES);

  // ------------------------------------------------------------
  // scan code set 2
  // ------------------------------------------------------------

  // prefix bytes
  localparam logic [7:0] SC_EXTENDED = 8'hE0;
  localparam logic [7:0] SC_BREAK = 8'hF0;

  // modifier keys
  localparam logic [7:0] SC_LSHIFT = 8'h12;
  localparam logic [7:0] SC_RSHIFT = 8'h59;
  localparam logic [7:0] SC_CAPS = 8'h58;

  // ------------------------------------------------------------
  // event queue and consumer credits
  // ------------------------------------------------------------

  // depth must stay a power of two
  localparam int EVQ_DEPTH = 8;
  localparam int EVQ_PTR_W = 3;

  // credits granted by the consumer at reset
  localparam int CONSUMER_CREDITS = 4;
  localparam int CREDIT_W = 3;

  // ------------------------------------------------------------
  // ascii
  // ------------------------------------------------------------

  // key has no character
  localparam logic [7:0] ASCII_NONE = 8'h00;

endpackage

`default_nettype wire

// File: logic/ps2_key_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_key_tracker import ps2_kbd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       rx_valid,
  input  wire logic [7:0] rx_byte,
  output logic            key_valid,
  output logic [7:0]      key_scan,
  output logic            key_extended,
  output logic            key_released,
  output logic            shift_on,
  output logic            caps_on
);

  // ------------------------------------------------------------
  // prefix decode
  // ------------------------------------------------------------

  logic ext_pend;
  logic brk_pend;
  logic is_ext;
  logic is_brk;
  logic is_key;
  // one flag per shift key so releasing one keeps the other held
  logic lshift_q;
  logic rshift_q;

  assign is_ext = (rx_byte == SC_EXTENDED);
  assign is_brk = (rx_byte == SC_BREAK);
  assign is_key = rx_valid && !is_ext && !is_brk;

  assign shift_on = lshift_q | rshift_q;

  // event payload
  always_ff @(posedge clk) begin
    if (is_key) begin
      key_scan <= rx_byte;
      key_extended <= ext_pend;
      key_released <= brk_pend;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_valid <= 1'b0;
      ext_pend <= 1'b0;
      brk_pend <= 1'b0;
      lshift_q <= 1'b0;
      rshift_q <= 1'b0;
      caps_on <= 1'b0;
    end else begin
      key_valid <= is_key;
      if (rx_valid && is_ext) begin
        ext_pend <= 1'b1;
      end
      if (rx_valid && is_brk) begin
        brk_pend <= 1'b1;
      end
      if (is_key) begin
        // prefixes apply to this key only
        ext_pend <= 1'b0;
        brk_pend <= 1'b0;
        // make sets, break clears
        if (rx_byte == SC_LSHIFT) begin
          lshift_q <= !brk_pend;
        end
        if (rx_byte == SC_RSHIFT) begin
          rshift_q <= !brk_pend;
        end
        // caps lock toggles on make only
        if (rx_byte == SC_CAPS && !brk_pend) begin
          caps_on <= !caps_on;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // caps lock state only moves together with a caps make event
  a_caps_on_make: assert property (@(posedge clk) disable iff (!rst_n)
    (caps_on != $past(caps_on)) |-> key_valid && key_scan == SC_CAPS && !key_released);

endmodule

`default_nettype wire

// File: logic/ps2_keyboard_top.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       ps2_clk,
  input  wire logic       ps2_data,
  input  wire logic       evt_credit,
  output logic            evt_valid,
  output logic [7:0]      evt_scan,
  output logic [7:0]      evt_ascii,
  output logic            evt_extended,
  output logic            evt_released,
  output logic            evt_overflow,
  output logic            frame_error,
  output logic            shift_on,
  output logic            caps_on
);

  // ------------------------------------------------------------
  // stage to stage wires
  // ------------------------------------------------------------

  // checked bytes
  logic       rx_valid;
  logic [7:0] rx_byte;

  // decoded key events
  logic       key_valid;
  logic [7:0] key_scan;
  logic       key_extended;
  logic       key_released;

  // translated events into the queue
  logic       map_valid;
  logic [7:0] map_scan;
  logic [7:0] map_ascii;
  logic       map_extended;
  logic       map_released;

  // ------------------------------------------------------------
  // pipeline
  // ------------------------------------------------------------

  ps2_frame_rx i_frame_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .frame_error (frame_error)
  );

  ps2_key_tracker i_key_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_valid     (rx_valid),
    .rx_byte      (rx_byte),
    .key_valid    (key_valid),
    .key_scan     (key_scan),
    .key_extended (key_extended),
    .key_released (key_released),
    .shift_on     (shift_on),
    .caps_on      (caps_on)
  );

  ps2_ascii_map i_ascii_map (
    .clk          (clk),
    .rst_n        (rst_n),
    .key_valid    (key_valid),
    .key_scan     (key_scan),
    .key_extended (key_extended),
    .key_released (key_released),
    .shift_on     (shift_on),
    .caps_on      (caps_on),
    .map_valid    (map_valid),
    .map_scan     (map_scan),
    .map_ascii    (map_ascii),
    .map_extended (map_extended),
    .map_released (map_released)
  );

  // credit handshake toward the consumer
  key_event_queue i_event_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_valid     (map_valid),
    .wr_scan      (map_scan),
    .wr_ascii     (map_ascii),
    .wr_extended  (map_extended),
    .wr_released  (map_released),
    .evt_credit   (evt_credit),
    .evt_valid    (evt_valid),
    .evt_scan     (evt_scan),
    .evt_ascii    (evt_ascii),
    .evt_extended (evt_extended),
    .evt_released (evt_released),
    .evt_overflow (evt_overflow)
  );

endmodule

`default_nettype wire

// File: verification/tb_ps2_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyboard import ps2_kbd_pkg::*; ();

  // ------------------------------------------------------------
  // setup
  // ------------------------------------------------------------

  // ps/2 half period in clk cycles
  localparam int PS2_HALF = 10;
  localparam int WAIT_LIMIT = 5000;
  localparam int NUM_ROWS = 28;

  // one table row: optional partial frame, up to three bytes, outcome
  typedef struct packed {
    logic [3:0] partial;
    logic [1:0] nbytes;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic       bad;
    logic       exp_err;
    logic       exp_shift;
    logic       exp_caps;
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       ps2_clk;
  logic       ps2_data;
  logic       evt_credit;
  logic       evt_valid;
  logic [7:0] evt_scan;
  logic [7:0] evt_ascii;
  logic       evt_extended;
  logic       evt_released;
  logic       evt_overflow;
  logic       frame_error;
  logic       shift_on;
  logic       caps_on;

  row_t stim_table [NUM_ROWS];
  logic [7:0] plain_keys [6] = '{8'h1C, 8'h32, 8'h21, 8'h16, 8'h1E, 8'h29};

  // expected events packed as scan, ascii, extended, released
  logic [17:0] exp_q [$];
  // cycle at which each owed credit goes back
  int unsigned due_q [$];
  int unsigned cycle_no = 0;
  int unsigned lcg_state = 32422;
  int delivered_cnt = 0;
  int frame_err_cnt = 0;
  int exp_frame_errors = 0;
  logic credits_held = 1'b0;

  // reference model state
  logic model_lshift = 1'b0;
  logic model_rshift = 1'b0;
  logic model_caps = 1'b0;

  ps2_keyboard_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .evt_credit   (evt_credit),
    .evt_valid    (evt_valid),
    .evt_scan     (evt_scan),
    .evt_ascii    (evt_ascii),
    .evt_extended (evt_extended),
    .evt_released (evt_released),
    .evt_overflow (evt_overflow),
    .frame_error  (frame_error),
    .shift_on     (shift_on),
    .caps_on      (caps_on)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected) else
      fail_now($sformatf("Mismatch at %0t ns: %s expected %02h actual %02h",
                         $time, name, expected, actual));
  endtask

  // lcg, upper bits give the credit delay 0..7
  function automatic int unsigned credit_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % 8;
  endfunction

  // expected character from the mapping rules, shifted form kept alongside
  function automatic logic [7:0] expected_ascii(input logic [7:0] sc, input logic ext,
                                                input logic shift, input logic caps);
    logic [7:0] plain;
    logic [7:0] upper;
    logic       letter;
    letter = 1'b0;
    plain = ASCII_NONE;
    upper = ASCII_NONE;
    case (sc)
      8'h1C: {letter, upper, plain} = {1'b1, "A", "a"};
      8'h32: {letter, upper, plain} = {1'b1, "B", "b"};
      8'h21: {letter, upper, plain} = {1'b1, "C", "c"};
      8'h16: {letter, upper, plain} = {1'b0, "!", "1"};
      8'h1E: {letter, upper, plain} = {1'b0, "@", "2"};
      8'h29: {letter, upper, plain} = {1'b0, " ", " "};
      8'h5A: {letter, upper, plain} = {1'b0, 8'h0D, 8'h0D};
      8'h66: {letter, upper, plain} = {1'b0, 8'h08, 8'h08};
      default: {letter, upper, plain} = {1'b0, ASCII_NONE, ASCII_NONE};
    endcase
    if (ext) begin
      return ASCII_NONE;
    end
    if (letter) begin
      return (shift ^ caps) ? upper : plain;
    end
    return shift ? upper : plain;
  endfunction

  task automatic push_expected(input logic [7:0] sc, input logic ext, input logic rel);
    exp_q.push_back({sc, expected_ascii(sc, ext, model_lshift | model_rshift, model_caps),
                     ext, rel});
  endtask

  // device side frame, data moves while ps2_clk is high
  task automatic send_frame(input logic [7:0] data, input logic bad_parity, input int nbits);
    logic [10:0] bits;
    logic        parity;
    parity = ~^data;
    if (bad_parity) begin
      parity = ~parity;
    end
    bits = {1'b1, parity, data, 1'b0};
    for (int i = 0; i < nbits; i++) begin
      ps2_data = bits[i];
      repeat (PS2_HALF) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (PS2_HALF) @(negedge clk);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (2 * PS2_HALF) @(negedge clk);
  endtask

  task automatic send_key(input logic [7:0] sc, input logic will_deliver);
    if (will_deliver) begin
      push_expected(sc, 1'b0, 1'b0);
    end
    send_frame(sc, 1'b0, FRAME_BITS);
  endtask

  // ------------------------------------------------------------
  // waits, each bounded
  // ------------------------------------------------------------

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 || due_q.size() != 0) begin
      if (n == WAIT_LIMIT) begin
        fail_now("Timeout: expected events or credit returns still outstanding");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_frame_errors(input int target);
    int n;
    n = 0;
    while (frame_err_cnt < target) begin
      if (n == WAIT_LIMIT) begin
        fail_now("Timeout: frame_error pulse never came for a corrupted frame");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_delivered(input int target);
    int n;
    n = 0;
    while (delivered_cnt < target) begin
      if (n == WAIT_LIMIT) begin
        fail_now("Timeout: fewer events delivered than the credits allow");
      end
      @(negedge clk);
      n++;
    end
  endtask

  // ------------------------------------------------------------
  // consumer and frame error monitor
  // ------------------------------------------------------------

  initial begin : consumer
    logic [17:0] exp;
    evt_credit = 1'b0;
    forever begin
      @(negedge clk);
      cycle_no++;
      evt_credit = 1'b0;
      // at most one credit back per cycle
      if (!credits_held && due_q.size() != 0 && due_q[0] <= cycle_no) begin
        evt_credit = 1'b1;
        void'(due_q.pop_front());
      end
      if (frame_error) begin
        frame_err_cnt++;
      end
      if (evt_valid) begin
        assert (exp_q.size() != 0) else
          fail_now("evt_valid fired with no event expected");
        exp = exp_q.pop_front();
        check_value("evt_scan", exp[17:10], evt_scan);
        check_value("evt_ascii", exp[9:2], evt_ascii);
        check_value("evt_extended", {7'd0, exp[1]}, {7'd0, evt_extended});
        check_value("evt_released", {7'd0, exp[0]}, {7'd0, evt_released});
        delivered_cnt++;
        due_q.push_back(cycle_no + credit_delay());
      end
    end
  end

  // ------------------------------------------------------------
  // table rows
  // ------------------------------------------------------------

  task automatic apply_row(input row_t row);
    logic [7:0] seq [3];
    logic [7:0] scan;
    logic       ext;
    logic       rel;
    seq[0] = row.b0;
    seq[1] = row.b1;
    seq[2] = row.b2;
    ext = 1'b0;
    rel = 1'b0;
    scan = seq[int'(row.nbytes) - 1];
    for (int i = 0; i < int'(row.nbytes); i++) begin
      if (seq[i] == SC_EXTENDED) begin
        ext = 1'b1;
      end else if (seq[i] == SC_BREAK) begin
        rel = 1'b1;
      end
    end
    if (row.exp_err) begin
      exp_frame_errors++;
    end else begin
      // model state moves before the character is picked
      if (scan == SC_LSHIFT) begin
        model_lshift = !rel;
      end
      if (scan == SC_RSHIFT) begin
        model_rshift = !rel;
      end
      if (scan == SC_CAPS && !rel) begin
        model_caps = !model_caps;
      end
      push_expected(scan, ext, rel);
    end
    // cut frame, then idle past the resync timeout
    if (row.partial != '0) begin
      send_frame(8'hA5, 1'b0, int'(row.partial));
      repeat (IDLE_TIMEOUT_CYCLES + 100) @(negedge clk);
    end
    for (int i = 0; i < int'(row.nbytes); i++) begin
      send_frame(seq[i], row.bad && (i == int'(row.nbytes) - 1), FRAME_BITS);
    end
    wait_frame_errors(exp_frame_errors);
    wait_drained();
    check_value("frame_error count", 8'(exp_frame_errors), 8'(frame_err_cnt));
    check_value("shift_on", {7'd0, row.exp_shift}, {7'd0, shift_on});
    check_value("caps_on", {7'd0, row.exp_caps}, {7'd0, caps_on});
  endtask

  // ------------------------------------------------------------
  // credit tests
  // ------------------------------------------------------------

  task automatic check_credit_hold();
    int base;
    base = delivered_cnt;
    credits_held = 1'b1;
    for (int i = 0; i < 6; i++) begin
      send_key(plain_keys[i], 1'b1);
    end
    wait_delivered(base + CONSUMER_CREDITS);
    repeat (100) @(negedge clk);
    check_value("delivered while held", 8'(CONSUMER_CREDITS), 8'(delivered_cnt - base));
    credits_held = 1'b0;
    wait_drained();
  endtask

  task automatic check_overflow();
    int base;
    base = delivered_cnt;
    check_value("evt_overflow", 8'd0, {7'd0, evt_overflow});
    credits_held = 1'b1;
    // one key more than credits plus queue entries
    for (int i = 0; i < CONSUMER_CREDITS + EVQ_DEPTH + 1; i++) begin
      send_key(plain_keys[i % 6], i < CONSUMER_CREDITS + EVQ_DEPTH);
    end
    wait_delivered(base + CONSUMER_CREDITS);
    check_value("evt_overflow", 8'd1, {7'd0, evt_overflow});
    check_value("delivered while held", 8'(CONSUMER_CREDITS), 8'(delivered_cnt - base));
    credits_held = 1'b0;
    wait_drained();
    // window for a stray dropped event to show up at the consumer
    repeat (200) @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    rst_n = 1'b0;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    // partial, nbytes, bytes, bad parity, error, shift, caps
    stim_table = '{
      '{4'd0, 2'd1, 8'h16, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // plain digit
      '{4'd0, 2'd1, 8'h1C, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // plain letter
      '{4'd0, 2'd1, 8'h29, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // space
      '{4'd0, 2'd1, 8'h5A, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // enter
      '{4'd0, 2'd1, 8'h66, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // backspace
      '{4'd0, 2'd1, 8'h12, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0},  // left shift down
      '{4'd0, 2'd1, 8'h1E, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0},
      '{4'd0, 2'd1, 8'h32, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0},
      '{4'd0, 2'd2, 8'hF0, 8'h12, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // left shift up
      '{4'd0, 2'd1, 8'h59, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0},  // right shift down
      '{4'd0, 2'd1, 8'h16, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0},
      '{4'd0, 2'd2, 8'hF0, 8'h59, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},
      '{4'd0, 2'd1, 8'h58, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1},  // caps on
      '{4'd0, 2'd2, 8'hF0, 8'h58, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1},  // caps break, no toggle
      '{4'd0, 2'd1, 8'h1C, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1},
      '{4'd0, 2'd1, 8'h12, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
      '{4'd0, 2'd1, 8'h1C, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},  // shift undoes caps
      '{4'd0, 2'd2, 8'hF0, 8'h1C, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
      '{4'd0, 2'd2, 8'hF0, 8'h12, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1},
      '{4'd0, 2'd1, 8'h58, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // caps off
      '{4'd0, 2'd2, 8'hF0, 8'h58, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},
      '{4'd0, 2'd2, 8'hF0, 8'h32, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // break only
      '{4'd0, 2'd2, 8'hE0, 8'h75, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // extended only
      '{4'd0, 2'd3, 8'hE0, 8'hF0, 8'h75, 1'b0, 1'b0, 1'b0, 1'b0},  // both prefixes
      '{4'd0, 2'd2, 8'hE0, 8'h5A, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},  // keypad enter
      '{4'd0, 2'd1, 8'h1C, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0, 1'b0},  // bad parity
      '{4'd0, 2'd1, 8'h1E, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},
      '{4'd5, 2'd1, 8'h21, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0}   // resync
    };
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // idle state out of reset
    check_value("evt_valid", 8'd0, {7'd0, evt_valid});
    check_value("evt_overflow", 8'd0, {7'd0, evt_overflow});
    check_value("frame_error", 8'd0, {7'd0, frame_error});
    check_value("shift_on", 8'd0, {7'd0, shift_on});
    check_value("caps_on", 8'd0, {7'd0, caps_on});
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(stim_table[r]);
    end
    check_credit_hold();
    check_overflow();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/ps2_kbd_pkg.sv
logic/ps2_frame_rx.sv
logic/ps2_key_tracker.sv
logic/ps2_ascii_map.sv
logic/key_event_queue.sv
logic/ps2_keyboard_top.sv
verification/tb_ps2_keyboard.sv
